/* common/elevator_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Elevator floor-request controller shared definitions
// Floor and queue sizes, floor and mask types, stage-to-stage structs
////////////////////////////////////////////////////////////////////////////

package elevator_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    // Floors served by the car, numbered 0 to 10
    localparam int num_floors = 11;

    // Bits of a floor number
    localparam int floor_width = 4;

    // Queue entries, at least num_floors so the queue never fills
    localparam int queue_depth = 16;

    // Queue pointer bits
    localparam int queue_addr_width = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number
    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, for buttons and lights
    typedef logic [num_floors-1:0] floor_mask_t;

    // Capture to queue, one accepted floor per cycle
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } request_t;

    // Oldest queued floor, valid while the queue holds anything
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } head_t;

    // Dispatch to capture, car has arrived at this floor
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } served_t;

endpackage

/* flist.f */
common/elevator_pkg.sv
logic/request_capture.sv
logic/request_queue.sv
logic/car_dispatch.sv
logic/floor_controller.sv
tests/floor_controller_checker.sv
tests/floor_controller_tb.sv

/* logic/car_dispatch.sv */
////////////////////////////////////////////////////////////////////////////
// Car dispatch stage
// Idle/travel FSM, activate strobe, arrival detection, door gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module car_dispatch (
    input  logic                  clock,
    input  logic                  reset_n,
    input  elevator_pkg::head_t   head,
    input  elevator_pkg::floor_t  current_floor,
    input  logic                  moving,
    input  logic                  halt,
    input  logic                  door_open_button,
    input  logic                  door_close_button,
    output logic                  pop,
    output elevator_pkg::served_t served,
    output elevator_pkg::floor_t  target_floor,
    output logic                  direction_up,
    output logic                  activate,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    import elevator_pkg::*;

    typedef enum logic {
        state_idle,
        state_travel
    } state_t;

    state_t state;
    logic   start;
    logic   arrived;

    // Take the oldest floor only with the car standing still
    assign start = (state == state_idle) && head.valid && !moving && !halt;
    assign pop   = start;

    // Car stopped at the floor it was sent to
    assign arrived = (state == state_travel) && !moving && (current_floor == target_floor);

    ////////////////////////////////////////////////////////////////////////////
    // Idle/travel control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= state_idle;
            activate     <= 1'b0;
            target_floor <= '0;
            direction_up <= 1'b0;
            served       <= '0;
        end else if (halt) begin
            state        <= state_idle;
            activate     <= 1'b0;
            served.valid <= 1'b0;
        end else begin
            activate     <= start;
            served.valid <= arrived;
            served.floor <= target_floor;
            if (start) begin
                state        <= state_travel;
                target_floor <= head.floor;
                direction_up <= (head.floor > current_floor);
            end else if (arrived) begin
                state <= state_idle;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////////////////////

    // Buttons pass through only while stopped and not halted
    assign door_open_allowed  = door_open_button && !moving && !halt;
    assign door_close_allowed = door_close_button && !moving && !halt;

endmodule

/* logic/floor_controller.sv */
////////////////////////////////////////////////////////////////////////////
// Elevator floor-request controller top level
// Capture, queue and dispatch stages wired in a pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_controller (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency,
    input  logic                      power_on,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      moving,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_up,
    output logic                      activate,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import elevator_pkg::*;

    request_t request;
    head_t    head;
    served_t  served;
    logic     pop;
    logic     halt;

    // Stage 1, buttons to lights and requests
    request_capture request_capture_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (current_floor),
        .power_on      (power_on),
        .emergency     (emergency),
        .served        (served),
        .request       (request),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .halt          (halt)
    );

    // Stage 2, pending floors in arrival order
    request_queue request_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .request (request),
        .pop     (pop),
        .halt    (halt),
        .head    (head)
    );

    // Stage 3, send the car and watch for arrival
    car_dispatch car_dispatch_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .head               (head),
        .current_floor      (current_floor),
        .moving             (moving),
        .halt               (halt),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .pop                (pop),
        .served             (served),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* logic/request_capture.sv */
////////////////////////////////////////////////////////////////////////////
// Request capture stage
// Button latching, call and panel lights, request selection, halt decision
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      power_on,
    input  logic                      emergency,
    input  elevator_pkg::served_t     served,
    output elevator_pkg::request_t    request,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output logic                      halt
);

    import elevator_pkg::*;

    floor_mask_t eligible;
    floor_mask_t accept_mask;
    floor_mask_t served_mask;
    logic        accept_valid;
    floor_t      accept_floor;

    // Single place where power and emergency are looked at
    assign halt = !power_on || emergency;

    ////////////////////////////////////////////////////////////////////////////
    // Eligibility and selection
    ////////////////////////////////////////////////////////////////////////////

    // Pressed, not where the car is, and not already pending
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            eligible[i] = (call_buttons[i] || panel_buttons[i]) &&
                          (current_floor != floor_t'(i)) &&
                          !call_lights[i] && !panel_lights[i];
        end
    end

    // Lowest-numbered eligible floor wins, the rest must keep pressing
    always_comb begin
        accept_valid = 1'b0;
        accept_floor = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                accept_valid = 1'b1;
                accept_floor = floor_t'(i);
            end
        end
        accept_valid = accept_valid && !halt;
    end

    assign accept_mask = accept_valid ? (floor_mask_t'(1) << accept_floor) : '0;
    assign served_mask = served.valid ? (floor_mask_t'(1) << served.floor) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Lights and request strobe
    ////////////////////////////////////////////////////////////////////////////

    // Only the button(s) actually pressed on the accepted floor light up
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else if (halt) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            call_lights  <= (call_lights | (accept_mask & call_buttons)) & ~served_mask;
            panel_lights <= (panel_lights | (accept_mask & panel_buttons)) & ~served_mask;
        end
    end

    // One-cycle strobe to the queue
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            request <= '0;
        end else begin
            request.valid <= accept_valid;
            request.floor <= accept_floor;
        end
    end

endmodule

/* logic/request_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Request queue stage
// Circular FIFO of pending floors in arrival order, flushed on halt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_queue (
    input  logic                   clock,
    input  logic                   reset_n,
    input  elevator_pkg::request_t request,
    input  logic                   pop,
    input  logic                   halt,
    output elevator_pkg::head_t    head
);

    import elevator_pkg::*;

    floor_t                      mem [queue_depth];
    logic [queue_addr_width-1:0] wr_ptr;
    logic [queue_addr_width-1:0] rd_ptr;
    logic [queue_addr_width:0]   count;
    logic                        push;
    logic                        pull;
    logic                        not_empty;

    // A floor is pending once at most, so there is always room
    assign push      = request.valid && !halt;
    assign not_empty = (count != '0);
    assign pull      = pop && not_empty;

    // Head is read straight out of storage
    assign head = '{valid: not_empty, floor: mem[rd_ptr]};

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= request.floor;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (halt) begin
            // Flush, nothing queued before a halt is served after it
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* tests/floor_controller_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the floor controller top-level ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_controller_checker (
    input logic                      clock,
    input logic                      reset_n,
    input logic                      emergency,
    input logic                      power_on,
    input logic                      moving,
    input logic                      activate,
    input logic                      door_open_allowed,
    input logic                      door_close_allowed,
    input elevator_pkg::floor_mask_t call_lights,
    input elevator_pkg::floor_mask_t panel_lights
);

    // Failed assertions so far, watched by the testbench
    int unsigned error_count = 0;

    // Activate is a one-cycle strobe
    activate_single: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate |=> !activate
    ) else begin
        $error("activate stayed high for two cycles");
        error_count++;
    end

    // Dispatch only starts with the car standing and no halt at the launching edge
    activate_safe: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate |-> $past(!moving && power_on && !emergency)
    ) else begin
        $error("activate raised while moving, in emergency or with power off");
        error_count++;
    end

    // Doors stay shut while travelling
    doors_shut_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        moving |-> (!door_open_allowed && !door_close_allowed)
    ) else begin
        $error("door output high while the car is moving");
        error_count++;
    end

    // A halt wipes every light by the next edge
    lights_cleared_on_halt: assert property (
        @(posedge clock) disable iff (!reset_n)
        (!power_on || emergency) |=> (call_lights == '0 && panel_lights == '0)
    ) else begin
        $error("lights still on one cycle after a halt");
        error_count++;
    end

endmodule

/* tests/floor_controller_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Floor controller testbench
// Clock, reset, car model, stimulus table, ordering, halt and door tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_controller_tb;

    import elevator_pkg::*;

    localparam int clock_period = 4;
    localparam int num_rows     = 5;
    localparam int row_cycles   = 40;
    localparam int num_sections = num_rows + 4;
    localparam int wait_limit   = 20;
    localparam int call_kind    = 0;
    localparam int panel_kind   = 1;
    localparam int both_kind    = 2;

    typedef struct {
        string name;
        int    kind;
        int    floor;
        int    exp_target;
        bit    exp_up;
    } row_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency;
    logic        power_on;
    floor_t      current_floor;
    logic        moving;
    floor_t      target_floor;
    logic        direction_up;
    logic        activate;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;
    integer      seed = 1;
    row_t        rows [num_rows];
    int          order [3] = '{3, 6, 1};
    int          checker_errors;

    floor_controller floor_controller_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency          (emergency),
        .power_on           (power_on),
        .current_floor      (current_floor),
        .moving             (moving),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    bind floor_controller floor_controller_checker floor_controller_checker_inst (.*);

    assign checker_errors = floor_controller_inst.floor_controller_checker_inst.error_count;

    always #(clock_period / 2) clock = ~clock;

    // Car model that travels a few cycles after each activate
    always begin : car_model
        int     travel;
        floor_t dest;
        @(negedge clock);
        if (reset_n && activate) begin
            dest   = target_floor;
            travel = 4 + ($unsigned($random(seed)) % 4);
            moving = 1'b1;
            repeat (travel) @(negedge clock);
            current_floor = dest;
            moving        = 1'b0;
        end
    end

    initial begin
        #(clock_period * row_cycles * num_sections);
        report_failure("watchdog expired before all tests finished");
    end

    // Watch the bound checker for concurrent assertion failures
    always @(checker_errors) begin
        check_true("checker", checker_errors == 0, "a concurrent assertion failed");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else
            report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d",
                                     name, expected, actual));
    endtask

    task automatic check_true(input string name, input bit cond, input string what);
        assert (cond) else
            report_failure($sformatf("%s: %s", name, what));
    endtask

    // Called just after a falling edge
    task automatic press_floor(input int kind, input int floor);
        call_buttons  = (kind != panel_kind) ? floor_mask_t'(1) << floor : '0;
        panel_buttons = (kind != call_kind) ? floor_mask_t'(1) << floor : '0;
    endtask

    task automatic release_buttons();
        call_buttons  = '0;
        panel_buttons = '0;
    endtask

    // Returns on the falling edge where activate is seen
    task automatic wait_activate(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!activate && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        check_true(name, activate, "activate never came");
    endtask

    // Returns on the rising edge that samples the car stopped
    task automatic wait_stop(input string name);
        int waited;
        waited = 0;
        @(posedge clock);
        while (moving && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        check_true(name, !moving, "car never stopped");
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value(name, 0, activate);
        end
    endtask

    // One press from a stopped idle car followed by the trip and the lights clearing
    task automatic run_row(input row_t r);
        int start_floor;
        start_floor = current_floor;
        press_floor(r.kind, r.floor);
        @(negedge clock);
        release_buttons();
        if (r.floor == start_floor) begin
            check_value({r.name, " call lights"}, 0, call_lights);
            check_value({r.name, " panel lights"}, 0, panel_lights);
            expect_quiet(r.name, 8);
            check_value({r.name, " target"}, r.exp_target, target_floor);
        end else begin
            check_value({r.name, " call light"}, r.kind != panel_kind, call_lights[r.floor]);
            check_value({r.name, " panel light"}, r.kind != call_kind, panel_lights[r.floor]);
            check_value({r.name, " early activate"}, 0, activate);
            @(negedge clock);
            check_value({r.name, " early activate"}, 0, activate);
            @(negedge clock);
            check_value({r.name, " activate"}, 1, activate);
            check_value({r.name, " target"}, r.exp_target, target_floor);
            check_value({r.name, " direction"}, r.exp_up, direction_up);
            wait_stop(r.name);
            @(negedge clock);
            check_true(r.name, (call_lights | panel_lights) != '0, "lights cleared too early");
            @(negedge clock);
            check_value({r.name, " call lights"}, 0, call_lights);
            check_value({r.name, " panel lights"}, 0, panel_lights);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock             = 1'b0;
        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power_on          = 1'b1;
        current_floor     = '0;
        moving            = 1'b0;
        rows[0] = '{"up_call_5", call_kind, 5, 5, 1'b1};
        rows[1] = '{"down_panel_2", panel_kind, 2, 2, 1'b0};
        rows[2] = '{"up_both_10", both_kind, 10, 10, 1'b1};
        rows[3] = '{"down_call_0", call_kind, 0, 0, 1'b0};
        rows[4] = '{"same_floor_panel", panel_kind, 0, 0, 1'b0};

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        check_value("reset activate", 0, activate);
        check_value("reset lights", 0, call_lights | panel_lights);
        check_value("reset target", 0, target_floor);
        check_value("reset direction", 0, direction_up);
        check_value("reset doors", 0, door_open_allowed | door_close_allowed);

        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end

        // Car at 0 so the first floor leaves at once and the rest queue behind it
        press_floor(call_kind, 8);
        @(negedge clock);
        release_buttons();
        wait_activate("order_first");
        check_value("order_first target", 8, target_floor);
        press_floor(panel_kind, order[0]);
        @(negedge clock);
        press_floor(call_kind, order[0]);
        @(negedge clock);
        press_floor(call_kind, order[1]);
        @(negedge clock);
        check_value("duplicate call light", 0, call_lights[order[0]]);
        press_floor(both_kind, order[2]);
        @(negedge clock);
        release_buttons();
        for (int i = 0; i < 3; i++) begin
            wait_activate("order");
            check_value("order target", order[i], target_floor);
            check_value("order direction", order[i] > current_floor, direction_up);
        end
        wait_stop("order_last");
        expect_quiet("no_duplicate", 12);

        // Emergency during a trip with two floors still queued
        press_floor(panel_kind, 9);
        @(negedge clock);
        release_buttons();
        wait_activate("halt_first");
        press_floor(call_kind, 4);
        @(negedge clock);
        press_floor(panel_kind, 2);
        @(negedge clock);
        release_buttons();
        emergency         = 1'b1;
        door_open_button  = 1'b1;
        door_close_button = 1'b1;
        @(negedge clock);
        check_value("emergency lights", 0, call_lights | panel_lights);
        wait_stop("emergency_travel");
        check_value("emergency doors", 0, door_open_allowed | door_close_allowed);
        @(negedge clock);
        emergency         = 1'b0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        expect_quiet("emergency_flushed", 16);
        check_value("emergency_flushed lights", 0, call_lights | panel_lights);

        // Power drops right after a press is latched
        press_floor(call_kind, 5);
        @(negedge clock);
        release_buttons();
        check_value("power call light", 1, call_lights[5]);
        power_on = 1'b0;
        @(negedge clock);
        check_value("power lights", 0, call_lights | panel_lights);
        power_on = 1'b1;
        expect_quiet("power_flushed", 12);

        // Doors follow their buttons only while stopped
        door_open_button = 1'b1;
        @(posedge clock);
        check_value("door open", 1, door_open_allowed);
        check_value("door close", 0, door_close_allowed);
        @(negedge clock);
        door_open_button  = 1'b0;
        door_close_button = 1'b1;
        @(posedge clock);
        check_value("door open", 0, door_open_allowed);
        check_value("door close", 1, door_close_allowed);
        @(negedge clock);
        door_close_button = 1'b0;
        press_floor(panel_kind, 4);
        @(negedge clock);
        release_buttons();
        wait_activate("door_trip");
        door_open_button  = 1'b1;
        door_close_button = 1'b1;
        @(posedge clock);
        check_value("door moving", 0, door_open_allowed | door_close_allowed);
        wait_stop("door_trip");
        check_value("door stopped open", 1, door_open_allowed);
        check_value("door stopped close", 1, door_close_allowed);
        @(negedge clock);
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        @(negedge clock);
        check_value("door_trip lights", 0, call_lights | panel_lights);

        $display("** PASS **");
        $finish;
    end

endmodule
